// File: Makefile
TOP = decode_issue_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f vlog.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f vlog.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP)

clean:
	rm -rf obj_dir

// File: include/decode_consts.svh
// Decode and issue widths
`ifndef DECODE_CONSTS_SVH
`define DECODE_CONSTS_SVH

// Data path and PC width
`define XLEN 32

// Register file addressing
`define REG_ADDR_W 5

// Branch, ALU and load-store
`define NUM_UNITS 3

// Branch and jump offset, JAL immediate plus the zero bit
`define PC_OFFSET_W 21

// Link registers x1 and x5, used for call and return hints
`define LINK_REG_A 5'd1
`define LINK_REG_B 5'd5

`endif

// File: src/alu_operand_prep.sv
// ALU operand and control formation
`timescale 1ns/1ps
`include "decode_consts.svh"

module alu_operand_prep (
    input  logic                      clk,
    input  logic                      stage_load,
    input  logic [`XLEN-1:0]          instruction,
    input  rv_isa_pkg::opcode_group_t opcode_group,
    input  logic [2:0]                fn3,
    input  logic [`XLEN-1:0]          decode_pc,
    input  logic [`XLEN-1:0]          rs1_data,
    input  logic [`XLEN-1:0]          rs2_data,
    input  logic [`REG_ADDR_W-1:0]    issue_rs2_addr,
    output logic [`XLEN:0]            alu_in1,
    output logic [`XLEN:0]            alu_in2,
    output issue_pkg::alu_logic_op_t  alu_logic_op,
    output logic                      alu_subtract,
    output logic                      alu_lshift,
    output logic                      alu_arith,
    output logic                      alu_shifter_path,
    output logic                      alu_slt_path,
    output logic [`REG_ADDR_W-1:0]    shift_amount
);

    logic                     upper_or_jump;
    logic                     sub_op;
    logic [`XLEN-1:0]         imm_sel;
    issue_pkg::alu_logic_op_t logic_op_sel;

    logic [`XLEN-1:0] pc_r;
    logic [`XLEN-1:0] imm_r;
    logic             rs1_from_reg;
    logic             rs2_from_reg;
    logic             shamt_from_reg;
    logic             arith_bit;
    logic             unsigned_cmp;
    logic [`XLEN-1:0] op1;
    logic [`XLEN-1:0] op2;

    // LUI, AUIPC, JAL and JALR all go through the adder
    assign upper_or_jump = opcode_group inside {rv_isa_pkg::LUI, rv_isa_pkg::AUIPC,
                                                rv_isa_pkg::JAL, rv_isa_pkg::JALR};
    assign sub_op = (fn3 == rv_isa_pkg::ADD_SUB) && instruction[30] &&
                    (opcode_group == rv_isa_pkg::ARITH);

    ////////////////////////////////////////////////////////////
    // Decode-side selection
    always_comb begin
        if (opcode_group inside {rv_isa_pkg::LUI, rv_isa_pkg::AUIPC}) begin
            imm_sel = {instruction[31:12], 12'b0};
        end else if (opcode_group inside {rv_isa_pkg::JAL, rv_isa_pkg::JALR}) begin
            // Link value is PC plus 4
            imm_sel = `XLEN'(4);
        end else begin
            imm_sel = `XLEN'(signed'(instruction[31:20]));
        end
    end

    always_comb begin
        case (fn3)
            rv_isa_pkg::XOR: logic_op_sel = issue_pkg::XOR;
            rv_isa_pkg::OR:  logic_op_sel = issue_pkg::OR;
            rv_isa_pkg::AND: logic_op_sel = issue_pkg::AND;
            default:         logic_op_sel = issue_pkg::ADD;
        endcase
        if (upper_or_jump) begin
            logic_op_sel = issue_pkg::ADD;
        end
    end

    always_ff @(posedge clk) begin
        if (stage_load) begin
            pc_r <= (opcode_group inside {rv_isa_pkg::AUIPC, rv_isa_pkg::JAL,
                                          rv_isa_pkg::JALR}) ? decode_pc : '0;
            imm_r          <= imm_sel;
            rs1_from_reg   <= ~upper_or_jump;
            rs2_from_reg   <= ~(upper_or_jump | (opcode_group == rv_isa_pkg::ARITH_IMM));
            shamt_from_reg <= (opcode_group == rv_isa_pkg::ARITH);
            arith_bit      <= instruction[30];
            unsigned_cmp   <= fn3[0];
            alu_logic_op   <= logic_op_sel;
            alu_subtract   <= ~upper_or_jump &
                              ((fn3 inside {rv_isa_pkg::SLT, rv_isa_pkg::SLTU}) | sub_op);
            alu_lshift     <= ~fn3[2];
            alu_shifter_path <= ~upper_or_jump &
                                (fn3 inside {rv_isa_pkg::SLL, rv_isa_pkg::SRL_SRA});
            alu_slt_path   <= ~upper_or_jump &
                              (fn3 inside {rv_isa_pkg::SLT, rv_isa_pkg::SLTU});
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue-side operands
    assign op1 = rs1_from_reg ? rs1_data : pc_r;
    assign op2 = rs2_from_reg ? rs2_data : imm_r;

    // Extra top bit carries the sign for signed compare, zero when unsigned
    assign alu_in1 = {op1[`XLEN-1] & ~unsigned_cmp, op1};
    assign alu_in2 = {op2[`XLEN-1] & ~unsigned_cmp, op2};

    // Shift-in bit for arithmetic right shift
    assign alu_arith    = op1[`XLEN-1] & arith_bit;
    assign shift_amount = shamt_from_reg ? rs2_data[`REG_ADDR_W-1:0] : issue_rs2_addr;

endmodule

// File: src/branch_operand_prep.sv
// Branch operand formation
`timescale 1ns/1ps
`include "decode_consts.svh"

module branch_operand_prep (
    input  logic                      clk,
    input  logic                      stage_load,
    input  logic [`XLEN-1:0]          instruction,
    input  rv_isa_pkg::opcode_group_t opcode_group,
    input  logic [2:0]                fn3,
    input  logic [`REG_ADDR_W-1:0]    rs1_addr,
    input  logic [`REG_ADDR_W-1:0]    rd_addr,
    output logic [`PC_OFFSET_W-1:0]   br_pc_offset,
    output logic                      br_use_signed,
    output logic                      br_is_call,
    output logic                      br_is_return,
    output logic                      br_jal,
    output logic                      br_jalr,
    output logic [2:0]                br_fn3
);

    logic [19:0]              jal_imm;
    logic [11:0]              jalr_imm;
    logic [11:0]              br_imm;
    logic [`PC_OFFSET_W-1:0]  pc_offset;
    logic                     rs1_link;
    logic                     rd_link;

    // Immediate layouts, jump and branch forms drop the zero bit
    assign jal_imm  = {instruction[31], instruction[19:12], instruction[20], instruction[30:21]};
    assign jalr_imm = instruction[31:20];
    assign br_imm   = {instruction[31], instruction[7], instruction[30:25], instruction[11:8]};

    always_comb begin
        case (opcode_group)
            rv_isa_pkg::JALR: pc_offset = `PC_OFFSET_W'(signed'(jalr_imm));
            rv_isa_pkg::JAL:  pc_offset = `PC_OFFSET_W'(signed'({jal_imm, 1'b0}));
            default:          pc_offset = `PC_OFFSET_W'(signed'({br_imm, 1'b0}));
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Return address stack hints
    assign rs1_link = (rs1_addr == `LINK_REG_A) || (rs1_addr == `LINK_REG_B);
    assign rd_link  = (rd_addr == `LINK_REG_A) || (rd_addr == `LINK_REG_B);

    always_ff @(posedge clk) begin
        if (stage_load) begin
            br_pc_offset  <= pc_offset;
            br_use_signed <= !(fn3 inside {rv_isa_pkg::BLTU, rv_isa_pkg::BGEU});
            br_is_call    <= (opcode_group inside {rv_isa_pkg::JAL, rv_isa_pkg::JALR}) && rd_link;
            // Swapping one link register for the other still counts as return
            br_is_return  <= (opcode_group == rv_isa_pkg::JALR) && rs1_link &&
                             (!rd_link || (rs1_addr != rd_addr));
            br_jal        <= (opcode_group == rv_isa_pkg::JAL);
            br_jalr       <= (opcode_group == rv_isa_pkg::JALR);
            br_fn3        <= fn3;
        end
    end

endmodule

// File: src/decode_issue.sv
// Decode and issue top level
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_issue (
    input  logic                     clk,
    input  logic                     rst,
    input  logic                     decode_valid,
    input  logic [`XLEN-1:0]         decode_pc,
    input  logic [`XLEN-1:0]         decode_instruction,
    output logic                     decode_advance,
    output logic [`REG_ADDR_W-1:0]   rs1_addr,
    output logic [`REG_ADDR_W-1:0]   rs2_addr,
    input  logic [`XLEN-1:0]         rs1_data,
    input  logic [`XLEN-1:0]         rs2_data,
    input  logic                     rs1_busy,
    input  logic                     rs2_busy,
    input  issue_pkg::unit_mask_t    unit_ready,
    input  logic                     issue_hold,
    input  logic                     issue_flush,
    output issue_pkg::unit_mask_t    issue_to,
    output logic                     instruction_issued,
    output logic [`XLEN-1:0]         issue_pc,
    output logic                     issue_valid_out,
    output logic [`XLEN:0]           alu_in1,
    output logic [`XLEN:0]           alu_in2,
    output issue_pkg::alu_logic_op_t alu_logic_op,
    output logic                     alu_subtract,
    output logic                     alu_lshift,
    output logic                     alu_arith,
    output logic                     alu_shifter_path,
    output logic                     alu_slt_path,
    output logic [`REG_ADDR_W-1:0]   shift_amount,
    output logic [`PC_OFFSET_W-1:0]  br_pc_offset,
    output logic                     br_use_signed,
    output logic                     br_is_call,
    output logic                     br_is_return,
    output logic                     br_jal,
    output logic                     br_jalr,
    output logic [2:0]               br_fn3
);

    rv_isa_pkg::opcode_group_t opcode_group;
    logic [2:0]                fn3;
    logic [`REG_ADDR_W-1:0]    rs1_addr_dec;
    logic [`REG_ADDR_W-1:0]    rs2_addr_dec;
    logic [`REG_ADDR_W-1:0]    rd_addr_dec;
    logic                      uses_rs1;
    logic                      uses_rs2;
    issue_pkg::unit_mask_t     unit_needed;
    logic                      stage_load;

    instr_decoder i_instr_decoder (
        .instruction  (decode_instruction),
        .opcode_group (opcode_group),
        .fn3          (fn3),
        .rs1_addr     (rs1_addr_dec),
        .rs2_addr     (rs2_addr_dec),
        .rd_addr      (rd_addr_dec),
        .uses_rs1     (uses_rs1),
        .uses_rs2     (uses_rs2),
        .unit_needed  (unit_needed)
    );

    issue_stage i_issue_stage (
        .clk                (clk),
        .rst                (rst),
        .decode_valid       (decode_valid),
        .decode_pc          (decode_pc),
        .rs1_addr_dec       (rs1_addr_dec),
        .rs2_addr_dec       (rs2_addr_dec),
        .uses_rs1           (uses_rs1),
        .uses_rs2           (uses_rs2),
        .unit_needed        (unit_needed),
        .rs1_busy           (rs1_busy),
        .rs2_busy           (rs2_busy),
        .unit_ready         (unit_ready),
        .issue_hold         (issue_hold),
        .issue_flush        (issue_flush),
        .decode_advance     (decode_advance),
        .stage_load         (stage_load),
        .rs1_addr           (rs1_addr),
        .rs2_addr           (rs2_addr),
        .issue_pc           (issue_pc),
        .issue_valid_out    (issue_valid_out),
        .issue_to           (issue_to),
        .instruction_issued (instruction_issued)
    );

    alu_operand_prep i_alu_operand_prep (
        .clk              (clk),
        .stage_load       (stage_load),
        .instruction      (decode_instruction),
        .opcode_group     (opcode_group),
        .fn3              (fn3),
        .decode_pc        (decode_pc),
        .rs1_data         (rs1_data),
        .rs2_data         (rs2_data),
        .issue_rs2_addr   (rs2_addr),
        .alu_in1          (alu_in1),
        .alu_in2          (alu_in2),
        .alu_logic_op     (alu_logic_op),
        .alu_subtract     (alu_subtract),
        .alu_lshift       (alu_lshift),
        .alu_arith        (alu_arith),
        .alu_shifter_path (alu_shifter_path),
        .alu_slt_path     (alu_slt_path),
        .shift_amount     (shift_amount)
    );

    branch_operand_prep i_branch_operand_prep (
        .clk           (clk),
        .stage_load    (stage_load),
        .instruction   (decode_instruction),
        .opcode_group  (opcode_group),
        .fn3           (fn3),
        .rs1_addr      (rs1_addr_dec),
        .rd_addr       (rd_addr_dec),
        .br_pc_offset  (br_pc_offset),
        .br_use_signed (br_use_signed),
        .br_is_call    (br_is_call),
        .br_is_return  (br_is_return),
        .br_jal        (br_jal),
        .br_jalr       (br_jalr),
        .br_fn3        (br_fn3)
    );

endmodule

// File: src/instr_decoder.sv
// Instruction field decoder
`timescale 1ns/1ps
`include "decode_consts.svh"

module instr_decoder (
    input  logic [`XLEN-1:0]         instruction,
    output rv_isa_pkg::opcode_group_t opcode_group,
    output logic [2:0]               fn3,
    output logic [`REG_ADDR_W-1:0]   rs1_addr,
    output logic [`REG_ADDR_W-1:0]   rs2_addr,
    output logic [`REG_ADDR_W-1:0]   rd_addr,
    output logic                     uses_rs1,
    output logic                     uses_rs2,
    output issue_pkg::unit_mask_t    unit_needed
);

    ////////////////////////////////////////////////////////////
    // Field slicing
    assign opcode_group = rv_isa_pkg::opcode_group_t'(instruction[6:2]);
    assign fn3          = instruction[14:12];
    assign rs1_addr     = instruction[19:15];
    assign rs2_addr     = instruction[24:20];
    assign rd_addr      = instruction[11:7];

    ////////////////////////////////////////////////////////////
    // Register use
    assign uses_rs1 = !(opcode_group inside {rv_isa_pkg::LUI, rv_isa_pkg::AUIPC,
                                             rv_isa_pkg::JAL, rv_isa_pkg::FENCE});
    assign uses_rs2 = opcode_group inside {rv_isa_pkg::BRANCH, rv_isa_pkg::STORE,
                                           rv_isa_pkg::ARITH};

    ////////////////////////////////////////////////////////////
    // Unit selection
    assign unit_needed[issue_pkg::BRANCH_UNIT] =
        opcode_group inside {rv_isa_pkg::BRANCH, rv_isa_pkg::JAL, rv_isa_pkg::JALR};

    // Bit 25 marks multiply and divide, which have no unit here
    assign unit_needed[issue_pkg::ALU_UNIT] =
        ((opcode_group == rv_isa_pkg::ARITH) && !instruction[25]) ||
        (opcode_group inside {rv_isa_pkg::ARITH_IMM, rv_isa_pkg::AUIPC, rv_isa_pkg::LUI,
                              rv_isa_pkg::JAL, rv_isa_pkg::JALR});

    assign unit_needed[issue_pkg::LS_UNIT] =
        opcode_group inside {rv_isa_pkg::LOAD, rv_isa_pkg::STORE};

endmodule

// File: src/issue_pkg.sv
// Issue stage types
`include "decode_consts.svh"

package issue_pkg;

    // Bit positions in the unit mask
    localparam int BRANCH_UNIT = 0;
    localparam int ALU_UNIT    = 1;
    localparam int LS_UNIT     = 2;

    // One bit per execution unit
    typedef logic [`NUM_UNITS-1:0] unit_mask_t;

    // Logic path selection inside the ALU
    typedef enum logic [1:0] {
        ADD = 2'b00,
        XOR = 2'b01,
        OR  = 2'b10,
        AND = 2'b11
    } alu_logic_op_t;

endpackage

// File: src/issue_stage.sv
// One-entry issue stage
`timescale 1ns/1ps
`include "decode_consts.svh"

module issue_stage (
    input  logic                   clk,
    input  logic                   rst,
    input  logic                   decode_valid,
    input  logic [`XLEN-1:0]       decode_pc,
    input  logic [`REG_ADDR_W-1:0] rs1_addr_dec,
    input  logic [`REG_ADDR_W-1:0] rs2_addr_dec,
    input  logic                   uses_rs1,
    input  logic                   uses_rs2,
    input  issue_pkg::unit_mask_t  unit_needed,
    input  logic                   rs1_busy,
    input  logic                   rs2_busy,
    input  issue_pkg::unit_mask_t  unit_ready,
    input  logic                   issue_hold,
    input  logic                   issue_flush,
    output logic                   decode_advance,
    output logic                   stage_load,
    output logic [`REG_ADDR_W-1:0] rs1_addr,
    output logic [`REG_ADDR_W-1:0] rs2_addr,
    output logic [`XLEN-1:0]       issue_pc,
    output logic                   issue_valid_out,
    output issue_pkg::unit_mask_t  issue_to,
    output logic                   instruction_issued
);

    logic                  stage_valid;
    logic                  stage_uses_rs1;
    logic                  stage_uses_rs2;
    issue_pkg::unit_mask_t stage_needed;

    logic issue_valid;
    logic rs1_conflict;
    logic rs2_conflict;
    logic operands_ready;
    logic units_ready;
    logic can_issue;
    logic no_unit;

    ////////////////////////////////////////////////////////////
    // Stage register
    always_ff @(posedge clk) begin
        if (rst || issue_flush) begin
            stage_valid <= 1'b0;
        end else if (decode_advance) begin
            stage_valid <= decode_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (decode_advance) begin
            issue_pc       <= decode_pc;
            rs1_addr       <= rs1_addr_dec;
            rs2_addr       <= rs2_addr_dec;
            stage_uses_rs1 <= uses_rs1;
            stage_uses_rs2 <= uses_rs2;
            stage_needed   <= unit_needed;
        end
    end

    ////////////////////////////////////////////////////////////
    // Issue decision
    assign issue_valid = stage_valid & ~issue_hold & ~issue_flush;

    assign rs1_conflict = rs1_busy & stage_uses_rs1;
    assign rs2_conflict = rs2_busy & stage_uses_rs2;

    // Load-store forwards rs2 itself and only waits on rs1
    assign operands_ready = stage_needed[issue_pkg::LS_UNIT] ? ~rs1_conflict :
                                                               ~(rs1_conflict | rs2_conflict);

    // Units not needed count as ready
    assign units_ready = &(unit_ready | ~stage_needed);
    assign can_issue   = issue_valid & operands_ready & units_ready & (|stage_needed);
    assign no_unit     = stage_valid & ~(|stage_needed);

    assign issue_to           = can_issue ? stage_needed : '0;
    assign instruction_issued = can_issue;
    assign issue_valid_out    = stage_valid;

    // Stage frees up when empty, issuing, or holding a unit-less instruction
    assign decode_advance = ~issue_hold & (~stage_valid | can_issue | no_unit);
    assign stage_load     = decode_advance;

endmodule

// File: src/rv_isa_pkg.sv
// RV32I encoding types
package rv_isa_pkg;

    // Upper five opcode bits, the low two are always 2'b11
    typedef enum logic [4:0] {
        LUI       = 5'b01101,
        AUIPC     = 5'b00101,
        JAL       = 5'b11011,
        JALR      = 5'b11001,
        BRANCH    = 5'b11000,
        LOAD      = 5'b00000,
        STORE     = 5'b01000,
        ARITH_IMM = 5'b00100,
        ARITH     = 5'b01100,
        FENCE     = 5'b00011,
        SYSTEM    = 5'b11100
    } opcode_group_t;

    // Function-3 codes for arithmetic and unsigned branches
    localparam logic [2:0] ADD_SUB = 3'b000;
    localparam logic [2:0] SLL     = 3'b001;
    localparam logic [2:0] SLT     = 3'b010;
    localparam logic [2:0] SLTU    = 3'b011;
    localparam logic [2:0] XOR     = 3'b100;
    localparam logic [2:0] SRL_SRA = 3'b101;
    localparam logic [2:0] OR      = 3'b110;
    localparam logic [2:0] AND     = 3'b111;
    localparam logic [2:0] BLTU    = 3'b110;
    localparam logic [2:0] BGEU    = 3'b111;

endpackage

// File: verification/decode_issue_sva.sv
// Issue handshake assertions
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_issue_sva (
    input logic                  clk,
    input logic                  rst,
    input logic                  stage_valid,
    input logic                  issue_hold,
    input logic                  decode_valid,
    input issue_pkg::unit_mask_t stage_needed,
    input issue_pkg::unit_mask_t issue_to
);

    // No strobe from an empty or held stage
    assert property (@(posedge clk) disable iff (rst)
        (!stage_valid || issue_hold) |-> (issue_to == '0))
        else $error("issue strobe from an empty or held stage");

    // Strobes only go to units the instruction needs
    assert property (@(posedge clk) disable iff (rst)
        ((issue_to & ~stage_needed) == '0))
        else $error("issue strobe to a unit that is not needed");

    // Nothing new loaded, so the same instruction must not strobe again
    assert property (@(posedge clk) disable iff (rst)
        ((issue_to != '0) && !decode_valid) |=> (issue_to == '0))
        else $error("same instruction issued twice");

endmodule

bind issue_stage decode_issue_sva i_decode_issue_sva (
    .clk          (clk),
    .rst          (rst),
    .stage_valid  (stage_valid),
    .issue_hold   (issue_hold),
    .decode_valid (decode_valid),
    .stage_needed (stage_needed),
    .issue_to     (issue_to)
);

// File: verification/decode_issue_tb.sv
// Decode and issue testbench
`timescale 1ns/1ps
`include "decode_consts.svh"

module decode_issue_tb;

    localparam int WAIT_LIMIT = 40;

    logic                       clk;
    logic                       rst;
    logic                       decode_valid;
    logic [`XLEN-1:0]           decode_pc;
    logic [`XLEN-1:0]           decode_instruction;
    logic                       decode_advance;
    logic [`REG_ADDR_W-1:0]     rs1_addr;
    logic [`REG_ADDR_W-1:0]     rs2_addr;
    logic [`XLEN-1:0]           rs1_data;
    logic [`XLEN-1:0]           rs2_data;
    logic                       rs1_busy;
    logic                       rs2_busy;
    issue_pkg::unit_mask_t      unit_ready;
    logic                       issue_hold;
    logic                       issue_flush;
    issue_pkg::unit_mask_t      issue_to;
    logic                       instruction_issued;
    logic [`XLEN-1:0]           issue_pc;
    logic                       issue_valid_out;
    logic [`XLEN:0]             alu_in1;
    logic [`XLEN:0]             alu_in2;
    issue_pkg::alu_logic_op_t   alu_logic_op;
    logic                       alu_subtract;
    logic                       alu_lshift;
    logic                       alu_arith;
    logic                       alu_shifter_path;
    logic                       alu_slt_path;
    logic [`REG_ADDR_W-1:0]     shift_amount;
    logic [`PC_OFFSET_W-1:0]    br_pc_offset;
    logic                       br_use_signed;
    logic                       br_is_call;
    logic                       br_is_return;
    logic                       br_jal;
    logic                       br_jalr;
    logic [2:0]                 br_fn3;

    // Current vector fields
    logic [8*16-1:0]            v_name;
    string                      test_name;
    logic [`XLEN-1:0]           v_pc;
    logic [`XLEN-1:0]           v_instr;
    logic [`XLEN-1:0]           v_rs1_data;
    logic [`XLEN-1:0]           v_rs2_data;
    int                         v_rs1_rel;
    int                         v_rs2_rel;
    issue_pkg::unit_mask_t      v_rdy_mask;
    int                         v_nr_cyc;
    int                         v_flush_at;
    int                         v_exp_cyc;
    issue_pkg::unit_mask_t      v_exp_mask;
    logic [`XLEN:0]             v_exp_in1;
    logic [`XLEN:0]             v_exp_in2;
    logic [`PC_OFFSET_W-1:0]    v_exp_off;
    logic [2:0]                 v_exp_flags;

    decode_issue i_decode_issue (.*);

    always begin
        #10;
        clk = ~clk;
    end

    task automatic abort_run(input string reason);
        $display("%0s", reason);
        $display("Errors found");
        $fatal(1, "simulation stopped");
    endtask

    task automatic check_field(input string what, input logic [63:0] expected,
                               input logic [63:0] actual);
        assert (actual == expected)
            else abort_run($sformatf("ERR %0s %0s expected %0h actual %0h",
                                     test_name, what, expected, actual));
    endtask

    ////////////////////////////////////////////////////////////
    // Per-cycle hazard and back-pressure model
    task automatic drive_cycle(input int c);
        rs1_busy    = (c < v_rs1_rel);
        rs2_busy    = (c < v_rs2_rel);
        unit_ready  = (c < v_nr_cyc) ? v_rdy_mask : '1;
        issue_flush = (v_flush_at != 0) && (c == v_flush_at);
    endtask

    task automatic present_instruction();
        int waited;
        @(posedge clk);
        #1;
        decode_valid       = 1'b1;
        decode_pc          = v_pc;
        decode_instruction = v_instr;
        rs1_data           = v_rs1_data;
        rs2_data           = v_rs2_data;
        rs1_busy           = 1'b0;
        rs2_busy           = 1'b0;
        unit_ready         = '1;
        issue_flush        = 1'b0;
        waited             = 0;
        @(negedge clk);
        while (!decode_advance) begin
            if (waited == WAIT_LIMIT) begin
                abort_run($sformatf("%0s was never accepted by the decode stage", test_name));
            end
            @(negedge clk);
            waited++;
        end
        // Accepted on this edge
        @(posedge clk);
        #1;
        decode_valid = 1'b0;
    endtask

    task automatic check_result(input int c);
        logic [2:0]               f3;
        logic                     reg_form;
        logic                     op_form;
        logic                     is_cmp;
        logic                     is_sub;
        issue_pkg::alu_logic_op_t exp_op;
        f3       = v_instr[14:12];
        reg_form = (v_instr[6:0] == 7'b0110011);
        op_form  = reg_form || (v_instr[6:0] == 7'b0010011);
        is_cmp   = op_form && (f3 inside {3'b010, 3'b011});
        is_sub   = reg_form && (f3 == 3'b000) && v_instr[30];
        // Logic ops only exist in the register and immediate forms
        case ({op_form, f3})
            4'b1100: exp_op = issue_pkg::XOR;
            4'b1110: exp_op = issue_pkg::OR;
            4'b1111: exp_op = issue_pkg::AND;
            default: exp_op = issue_pkg::ADD;
        endcase
        check_field("issue cycle", 64'(v_exp_cyc), 64'(c));
        check_field("issue_to", 64'(v_exp_mask), 64'(issue_to));
        check_field("instruction_issued", 64'(v_exp_mask != '0), 64'(instruction_issued));
        check_field("issue_valid_out", 64'(v_flush_at == 0), 64'(issue_valid_out));
        if (v_exp_mask != '0) begin
            check_field("issue_pc", 64'(v_pc), 64'(issue_pc));
            check_field("rs1_addr", 64'(v_instr[19:15]), 64'(rs1_addr));
            check_field("rs2_addr", 64'(v_instr[24:20]), 64'(rs2_addr));
        end
        if (v_exp_mask[issue_pkg::ALU_UNIT]) begin
            check_field("alu_in1", 64'(v_exp_in1), 64'(alu_in1));
            check_field("alu_in2", 64'(v_exp_in2), 64'(alu_in2));
            check_field("alu_logic_op", 64'(exp_op), 64'(alu_logic_op));
            check_field("alu_subtract", 64'(is_cmp || is_sub), 64'(alu_subtract));
            check_field("alu_slt_path", 64'(is_cmp), 64'(alu_slt_path));
            check_field("alu_shifter_path", 64'(op_form && (f3[1:0] == 2'b01)),
                        64'(alu_shifter_path));
            check_field("alu_lshift", 64'(!f3[2]), 64'(alu_lshift));
            check_field("alu_arith", 64'(v_instr[30] & v_exp_in1[`XLEN-1]), 64'(alu_arith));
            check_field("shift_amount",
                        64'(reg_form ? v_rs2_data[`REG_ADDR_W-1:0] : v_instr[24:20]),
                        64'(shift_amount));
        end
        if (v_exp_mask[issue_pkg::BRANCH_UNIT]) begin
            check_field("br_pc_offset", 64'(v_exp_off), 64'(br_pc_offset));
            check_field("branch flags", 64'(v_exp_flags),
                        64'({br_use_signed, br_is_call, br_is_return}));
            check_field("br_jal", 64'(v_instr[6:0] == 7'b1101111), 64'(br_jal));
            check_field("br_jalr", 64'(v_instr[6:0] == 7'b1100111), 64'(br_jalr));
            check_field("br_fn3", 64'(f3), 64'(br_fn3));
        end
    endtask

    // Holds the stage until it issues or frees up
    task automatic run_stage();
        int   c;
        logic done;
        c    = 0;
        done = 1'b0;
        while (!done) begin
            drive_cycle(c);
            @(negedge clk);
            if (decode_advance || instruction_issued) begin
                done = 1'b1;
                check_result(c);
            end else begin
                assert (issue_to == '0)
                    else abort_run($sformatf("ERR %0s strobe while held expected 0 actual %0h",
                                             test_name, issue_to));
                if (c == WAIT_LIMIT) begin
                    abort_run($sformatf("%0s stayed in the issue stage too long", test_name));
                end
                @(posedge clk);
                #1;
                c++;
            end
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    initial begin
        int    fd;
        int    n;
        int    vectors;
        string line;
        clk                = 1'b0;
        rst                = 1'b1;
        decode_valid       = 1'b0;
        decode_pc          = '0;
        decode_instruction = '0;
        rs1_data           = '0;
        rs2_data           = '0;
        rs1_busy           = 1'b0;
        rs2_busy           = 1'b0;
        unit_ready         = '1;
        issue_hold         = 1'b0;
        issue_flush        = 1'b0;
        vectors            = 0;
        fd = $fopen("verification/decode_issue_testdata.txt", "r");
        if (fd == 0) begin
            abort_run("could not open the test vector file");
        end
        repeat (10) @(posedge clk);
        #1;
        rst = 1'b0;
        while ($fgets(line, fd) != 0) begin
            if (line.len() > 1 && line[0] != "#") begin
                n = $sscanf(line, "%s %h %h %h %h %d %d %b %d %d %d %b %h %h %h %b",
                            v_name, v_pc, v_instr, v_rs1_data, v_rs2_data,
                            v_rs1_rel, v_rs2_rel, v_rdy_mask, v_nr_cyc, v_flush_at,
                            v_exp_cyc, v_exp_mask, v_exp_in1, v_exp_in2, v_exp_off,
                            v_exp_flags);
                if (n != 16) begin
                    abort_run($sformatf("malformed test vector line: %0s", line));
                end
                test_name = $sformatf("%0s", v_name);
                present_instruction();
                run_stage();
                vectors++;
            end
        end
        $fclose(fd);
        if (vectors == 0) begin
            abort_run("no test vectors were found in the vector file");
        end else begin
            $display("No errors");
            $finish;
        end
    end

endmodule

// File: verification/decode_issue_testdata.txt
# name pc instr rs1_data rs2_data rs1_rel rs2_rel rdy_mask nr_cyc flush_at exp_cyc
# exp_mask exp_in1 exp_in2 exp_off exp_flags, masks and flags in binary, flags = signed call return
lui        00001000 123451b7 000000aa 000000bb 0 0 111 0 0 0 010 000000000 012345000 000000 000
auipc      00002000 00010217 000000aa 000000bb 0 0 111 0 0 0 010 000002000 000010000 000000 000
addi       00002004 ffd30293 00000100 000000bb 0 0 111 0 0 0 010 000000100 1fffffffd 000000 000
jal_call   00003000 001000ef 00000000 00000000 0 0 111 0 0 0 011 000003000 000000004 000800 110
jalr_ret   00003800 00008067 00003004 00000000 0 0 111 0 0 0 011 000003800 000000004 000000 101
jalr_swap  00004000 010280e7 00004004 00000000 0 0 111 0 0 0 011 000004000 000000004 000010 111
jalr_same  00004100 ff8080e7 00004104 00000000 0 0 111 0 0 0 011 000004100 000000004 1ffff8 110
beq        00005000 fe3108e3 00000001 00000001 0 0 111 0 0 0 001 000000000 000000000 1ffff0 100
bltu       00005004 00526463 00000001 00000002 0 0 111 0 0 0 001 000000000 000000000 000008 000
bgeu       00005008 1020f063 00000003 00000004 0 0 111 0 0 0 001 000000000 000000000 000100 000
add_rs2    00006000 009403b3 00000011 00000022 0 3 111 0 0 3 010 000000011 000000022 000000 000
load_rs2   00006004 0045a503 00000200 00000033 0 4 111 0 0 0 100 000000000 000000000 000000 000
store_rs2  00006008 00c6a423 00000200 00000044 0 4 111 0 0 0 100 000000000 000000000 000000 000
load_rs1   0000600c 0045a503 00000200 00000033 2 0 111 0 0 2 100 000000000 000000000 000000 000
alu_stall  00007000 7ff10093 00000001 00000000 0 0 101 4 0 4 010 000000001 0000007ff 000000 000
br_stall   00007100 020002ef 00000000 00000000 0 0 110 2 0 2 011 000007100 000000004 000020 110
system     00007200 00000073 00000000 00000000 0 0 000 5 0 0 000 000000000 000000000 000000 000
flush      00008000 009403b3 00000011 00000022 10 0 111 0 2 3 000 000000000 000000000 000000 000
sub        00008004 403100b3 00000050 00000030 0 0 111 0 0 0 010 000000050 000000030 000000 000
slt        00008008 003120b3 fffffff0 00000005 0 0 111 0 0 0 010 1fffffff0 000000005 000000 000
sltu       0000800c 003130b3 fffffff0 00000005 0 0 111 0 0 0 010 0fffffff0 000000005 000000 000

// File: vlog.f
+incdir+include
src/rv_isa_pkg.sv
src/issue_pkg.sv
src/instr_decoder.sv
src/issue_stage.sv
src/alu_operand_prep.sv
src/branch_operand_prep.sv
src/decode_issue.sv
verification/decode_issue_sva.sv
verification/decode_issue_tb.sv
